/* Bender.yml */
package:
  name: start_op_dispatch

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/op_class_decode.sv
      - design/hazard_gate.sv
      - design/ea_fetch_route.sv
      - design/start_op_dispatch.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_start_op_dispatch.sv

/* design/ea_fetch_route.sv */
// EA fetch router that picks the extension-word fetch state for modes 5 to 7.
`include "fetch_config.svh"

module ea_fetch_route
    import fetch_pkg::*;
(
    input  op_info_t     info,
    input  instr_t       instr,
    output fetch_state_t ea_state
);

    logic [2:0] ea_mode;
    logic [2:0] ea_reg;
    logic       is_long;

    assign ea_mode = instr.biw_0[`FETCH_EA_MODE_MSB:`FETCH_EA_MODE_LSB];
    assign ea_reg  = instr.biw_0[`FETCH_EA_REG_MSB:`FETCH_EA_REG_LSB];

    // MOVE carries its own size code in the opword.
    assign is_long = (info.op_class == CLS_MOVE) ? (instr.biw_0[13:12] == 2'b10)
                                                 : (instr.op_size == LONG);

    always_comb begin : route
        case (ea_mode)
            3'd5: begin
                ea_state = FETCH_DISPL; // d16(An).
            end
            3'd6: begin
                ea_state = FETCH_EXWORD_1; // Indexed.
            end
            default: begin
                // Mode 7 and memory shifts in other modes land here.
                if (ea_reg == 3'd0) begin
                    ea_state = FETCH_ABS_LO; // Absolute short.
                end else if (ea_reg == 3'd1 || info.op_class == CLS_SHIFT) begin
                    ea_state = FETCH_ABS_HI;
                end else if (ea_reg == 3'd4) begin
                    ea_state = is_long ? FETCH_IDATA_B2 : FETCH_IDATA_B1;
                end else if (ea_reg == 3'd2) begin
                    ea_state = FETCH_DISPL; // d16(PC).
                end else begin
                    ea_state = FETCH_EXWORD_1;
                end
            end
        endcase
    end

endmodule

/* design/fetch_config.svh */
// Fetch decision configuration with field widths and bit positions for the START_OP decision.
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Operation code as delivered by the opword decoder.
`define FETCH_OP_W 7

// First instruction word without its upper two bits.
`define FETCH_BIW_W 14

// Fetch pipeline state register.
`define FETCH_STATE_W 5

// Operand size code (byte, word, long).
`define FETCH_SIZE_W 2

// Decision class of an operation.
`define FETCH_CLASS_W 4

// Effective address mode field inside the first instruction word.
`define FETCH_EA_MODE_MSB 5
`define FETCH_EA_MODE_LSB 3

// Effective address register field inside the first instruction word.
`define FETCH_EA_REG_MSB 2
`define FETCH_EA_REG_LSB 0

`endif

/* design/fetch_pkg.sv */
// Fetch package with operation codes, decision classes, fetch states and bundled inputs.
`include "fetch_config.svh"

package fetch_pkg;

    // Operation codes grouped by decision class with a fresh base per group.
    typedef enum logic [`FETCH_OP_W-1:0] {
        // Traps and illegal operations.
        OP_ILLEGAL = 7'h00, OP_RTE, OP_TRAP, OP_UNIMPLEMENTED,
        // Register-only operations.
        OP_DBCC = 7'h08, OP_EXT, OP_EXTB, OP_MOVEQ, OP_SWAP,
        // Extended and BCD operations.
        OP_ABCD = 7'h10, OP_SBCD, OP_ADDX, OP_SUBX, OP_PACK, OP_UNPK,
        // Destination is an ALU operand.
        OP_ADD = 7'h18, OP_ADDI, OP_ADDQ, OP_AND_B, OP_ANDI, OP_CAS, OP_CMP,
        OP_CMPI, OP_EOR, OP_EORI, OP_NBCD, OP_NEG, OP_NEGX, OP_NOT_B,
        OP_OR_B, OP_ORI, OP_SUB, OP_SUBI, OP_SUBQ, OP_TST, OP_TAS,
        // Source is an ALU operand.
        OP_ADDA = 7'h30, OP_BCHG, OP_BCLR, OP_BFCHG, OP_BFCLR, OP_BFEXTS,
        OP_BFEXTU, OP_BFFFO, OP_BFINS, OP_BFSET, OP_BFTST, OP_BSET, OP_BTST,
        OP_CHK, OP_CHK2, OP_CMP2, OP_CMPA, OP_DIVS, OP_DIVU, OP_MULS, OP_MULU,
        OP_MOVEA, OP_MOVE_TO_CCR, OP_MOVE_TO_SR, OP_SUBA,
        // Shifts and rotates.
        OP_ASL = 7'h50, OP_ASR, OP_LSL, OP_LSR, OP_ROTL, OP_ROTR, OP_ROXL, OP_ROXR,
        OP_MOVE = 7'h58,
        // Status register writers.
        OP_ANDI_TO_CCR = 7'h60, OP_ANDI_TO_SR, OP_EORI_TO_CCR, OP_EORI_TO_SR,
        OP_ORI_TO_CCR, OP_ORI_TO_SR, OP_RESET,
        // Branches and other simple operations.
        OP_BCC = 7'h68, OP_BRA, OP_NOP, OP_STOP, OP_TRAPV
    } op_t;

    typedef enum logic [`FETCH_CLASS_W-1:0] {
        CLS_TRAP    = 4'd0,
        CLS_REG     = 4'd1,
        CLS_XREG    = 4'd2,
        CLS_ALU_DST = 4'd3,
        CLS_ALU_SRC = 4'd4,
        CLS_SHIFT   = 4'd5,
        CLS_MOVE    = 4'd6,
        CLS_SR_WAIT = 4'd7,
        CLS_DEFAULT = 4'd8
    } op_class_t;

    typedef struct packed {
        op_class_t op_class;
        logic      strict; // Register-direct also waits on the other file.
    } op_info_t;

    typedef enum logic [`FETCH_STATE_W-1:0] {
        START_OP       = 5'd0,
        CALC_AEFF      = 5'd1,
        FETCH_DISPL    = 5'd2,
        FETCH_EXWORD_1 = 5'd3,
        FETCH_ABS_HI   = 5'd8,
        FETCH_ABS_LO   = 5'd9,
        FETCH_IDATA_B2 = 5'd10,
        FETCH_IDATA_B1 = 5'd11,
        FETCH_OPERAND  = 5'd13,
        INIT_EXEC_WB   = 5'd14
    } fetch_state_t;

    typedef enum logic [`FETCH_SIZE_W-1:0] {
        BYTE = 2'b00,
        WORD = 2'b01,
        LONG = 2'b10
    } op_size_t;

    typedef struct packed {
        op_t                     op;
        logic [`FETCH_BIW_W-1:0] biw_0;
        op_size_t                op_size;
    } instr_t;

    typedef struct packed {
        logic dr_in_use; // Data register write pending.
        logic ar_in_use; // Address register write pending.
        logic alu_bsy;
    } hazard_t;

endpackage

/* design/hazard_gate.sv */
// Hazard gate that applies register and ALU-busy waits per class and addressing mode.
`include "fetch_config.svh"

module hazard_gate
    import fetch_pkg::*;
(
    input  op_info_t     info,
    input  instr_t       instr,
    input  hazard_t      hazard,
    output fetch_state_t gate_state,
    output logic         use_ea_route
);

    logic [2:0]   ea_mode;
    logic         strict_dn;    // Dn source must also wait on An.
    logic         strict_an;    // An destination must also wait on Dn.
    logic         mem_shift;
    fetch_state_t common_state;
    logic         common_ea;

    assign ea_mode   = instr.biw_0[`FETCH_EA_MODE_MSB:`FETCH_EA_MODE_LSB];
    assign strict_dn = info.strict && (info.op_class == CLS_ALU_SRC);
    assign strict_an = info.strict && (info.op_class == CLS_ALU_DST);
    assign mem_shift = (instr.biw_0[7:6] == 2'b11); // Size field 11 selects memory form.

    // Mode rules shared by ALU and MOVE classes.
    always_comb begin : common_rules
        common_state = START_OP;
        common_ea    = 1'b0;
        case (ea_mode)
            3'd0: begin // Dn.
                if (!hazard.dr_in_use && !(strict_dn && hazard.ar_in_use)) begin
                    common_state = INIT_EXEC_WB;
                end
            end
            3'd1: begin // An.
                if (!hazard.ar_in_use && !(strict_an && hazard.dr_in_use)) begin
                    common_state = INIT_EXEC_WB;
                end
            end
            3'd2, 3'd3: begin // (An), (An)+.
                if (!hazard.ar_in_use) begin
                    common_state = FETCH_OPERAND;
                end
            end
            3'd4: begin // -(An).
                if (!hazard.ar_in_use) begin
                    common_state = CALC_AEFF;
                end
            end
            default: begin
                common_ea = 1'b1; // Extension words needed.
            end
        endcase
    end

    always_comb begin : class_rules
        gate_state   = START_OP;
        use_ea_route = 1'b0;
        case (info.op_class)
            CLS_TRAP: begin
                gate_state = START_OP; // Never leaves START_OP.
            end
            CLS_REG: begin
                if (!hazard.dr_in_use) begin
                    gate_state = INIT_EXEC_WB;
                end
            end
            CLS_XREG: begin
                if (!instr.biw_0[3] && !hazard.dr_in_use) begin
                    gate_state = INIT_EXEC_WB; // Register to register.
                end else if (instr.biw_0[3] && !hazard.ar_in_use) begin
                    gate_state = CALC_AEFF; // Predecrement memory to memory.
                end
            end
            CLS_ALU_DST, CLS_ALU_SRC, CLS_MOVE: begin
                gate_state   = common_state;
                use_ea_route = common_ea;
            end
            CLS_SHIFT: begin
                if (!mem_shift) begin
                    if (!hazard.dr_in_use) begin
                        gate_state = INIT_EXEC_WB;
                    end
                end else if (ea_mode inside {3'd2, 3'd3, 3'd4}) begin
                    gate_state = common_state;
                end else begin
                    use_ea_route = 1'b1;
                end
            end
            CLS_SR_WAIT: begin
                if (!hazard.alu_bsy) begin
                    gate_state = INIT_EXEC_WB;
                end
            end
            default: begin
                gate_state = INIT_EXEC_WB; // No hazard check needed.
            end
        endcase
    end

endmodule

/* design/op_class_decode.sv */
// Operation class decoder that maps an operation code to its decision class and strict flag.
`include "fetch_config.svh"

module op_class_decode
    import fetch_pkg::*;
(
    input  op_t      op,
    output op_info_t info
);

    always_comb begin : class_table
        info.op_class = CLS_DEFAULT;
        info.strict   = 1'b0; // Most operations touch one register file only.
        case (op)
            OP_ILLEGAL, OP_RTE, OP_TRAP, OP_UNIMPLEMENTED: begin
                info.op_class = CLS_TRAP; // Handled by the exception path.
            end
            OP_DBCC, OP_EXT, OP_EXTB, OP_MOVEQ, OP_SWAP: begin
                info.op_class = CLS_REG;
            end
            OP_ABCD, OP_SBCD, OP_ADDX, OP_SUBX, OP_PACK, OP_UNPK: begin
                info.op_class = CLS_XREG;
            end
            // Dn,An forms read both register files.
            OP_ADD, OP_SUB, OP_AND_B, OP_EOR, OP_OR_B, OP_CMP: begin
                info.op_class = CLS_ALU_DST;
                info.strict   = 1'b1;
            end
            OP_ADDI, OP_ADDQ, OP_ANDI, OP_CAS, OP_CMPI, OP_EORI, OP_NBCD,
            OP_NEG, OP_NEGX, OP_NOT_B, OP_ORI, OP_SUBI, OP_SUBQ, OP_TST,
            OP_TAS: begin
                info.op_class = CLS_ALU_DST;
            end
            OP_ADDA, OP_SUBA, OP_CMPA, OP_MOVEA: begin
                info.op_class = CLS_ALU_SRC;
                info.strict   = 1'b1; // Address register is the destination.
            end
            OP_BCHG, OP_BCLR, OP_BFCHG, OP_BFCLR, OP_BFEXTS, OP_BFEXTU,
            OP_BFFFO, OP_BFINS, OP_BFSET, OP_BFTST, OP_BSET, OP_BTST,
            OP_CHK, OP_CHK2, OP_CMP2, OP_DIVS, OP_DIVU, OP_MULS, OP_MULU,
            OP_MOVE_TO_CCR, OP_MOVE_TO_SR: begin
                info.op_class = CLS_ALU_SRC;
            end
            OP_ASL, OP_ASR, OP_LSL, OP_LSR, OP_ROTL, OP_ROTR, OP_ROXL,
            OP_ROXR: begin
                info.op_class = CLS_SHIFT;
            end
            OP_MOVE: begin
                info.op_class = CLS_MOVE;
            end
            OP_ANDI_TO_CCR, OP_ANDI_TO_SR, OP_EORI_TO_CCR, OP_EORI_TO_SR,
            OP_ORI_TO_CCR, OP_ORI_TO_SR, OP_RESET: begin
                info.op_class = CLS_SR_WAIT; // Condition codes must settle first.
            end
            default: begin
                // Bcc, BRA, NOP, STOP, TRAPV and unknown codes.
                info.op_class = CLS_DEFAULT;
            end
        endcase
    end

endmodule

/* design/start_op_dispatch.sv */
// START_OP dispatch that combines class, hazard and EA decisions into the fetch-state register.
`include "fetch_config.svh"

module start_op_dispatch
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  instr_t       instr,
    input  hazard_t      hazard,
    input  logic         opd_ack,
    input  logic         ow_rdy,
    output fetch_state_t fetch_state
);

    op_info_t     info;
    fetch_state_t gate_state;
    fetch_state_t ea_state;
    fetch_state_t next_state;
    logic         use_ea_route;
    logic         avail;

    op_class_decode op_class_decode_i (
        .op   (instr.op),
        .info (info)
    );

    hazard_gate hazard_gate_i (
        .info         (info),
        .instr        (instr),
        .hazard       (hazard),
        .gate_state   (gate_state),
        .use_ea_route (use_ea_route)
    );

    ea_fetch_route ea_fetch_route_i (
        .info     (info),
        .instr    (instr),
        .ea_state (ea_state)
    );

    assign avail = opd_ack || ow_rdy; // Operand or opword present.

    always_comb begin : select
        if (!avail) begin
            next_state = START_OP; // Nothing to decode yet.
        end else if (use_ea_route) begin
            next_state = ea_state;
        end else begin
            next_state = gate_state;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin : state_reg
        if (!arst_n) begin
            fetch_state <= START_OP;
        end else begin
            fetch_state <= next_state;
        end
    end

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset generator with a free-running clock and an active-low reset.
module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin : clock_proc
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin : reset_proc
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD_NS / 4) arst_n = 1'b1; // Released away from both clock edges.
    end

endmodule

/* testbench/tb_start_op_dispatch.sv */
// START_OP dispatch testbench with random vectors checked against a fetch-state model.
module tb_start_op_dispatch
    import fetch_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 100;
    localparam int NUM_VECTORS   = 2000;
    localparam int TIMEOUT_NS    = (NUM_VECTORS + 20) * CLK_PERIOD_NS * 2;

    logic         clk;
    logic         arst_n;
    instr_t       instr;
    hazard_t      hazard;
    logic         opd_ack;
    logic         ow_rdy;
    fetch_state_t fetch_state;

    logic [31:0]  lcg_state = 32'd41757;
    int           error_count = 0;
    int           check_count = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) clock_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    start_op_dispatch dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .hazard      (hazard),
        .opd_ack     (opd_ack),
        .ow_rdy      (ow_rdy),
        .fetch_state (fetch_state)
    );

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16]; // Upper bits have the longest period.
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0d ns", name, got, exp, $time);
        end
    endtask

    // Class from the code range of each package group.
    function automatic op_class_t class_of(input logic [6:0] code);
        if (code <= 7'h03)                      return CLS_TRAP;
        else if (code >= 7'h08 && code <= 7'h0c) return CLS_REG;
        else if (code >= 7'h10 && code <= 7'h15) return CLS_XREG;
        else if (code >= 7'h18 && code <= 7'h2c) return CLS_ALU_DST;
        else if (code >= 7'h30 && code <= 7'h48) return CLS_ALU_SRC;
        else if (code >= 7'h50 && code <= 7'h57) return CLS_SHIFT;
        else if (code == 7'h58)                 return CLS_MOVE;
        else if (code >= 7'h60 && code <= 7'h66) return CLS_SR_WAIT;
        else                                    return CLS_DEFAULT;
    endfunction

    function automatic logic strict_of(input logic [6:0] code);
        case (code)
            OP_ADD, OP_SUB, OP_AND_B, OP_EOR, OP_OR_B, OP_CMP: return 1'b1;
            OP_ADDA, OP_SUBA, OP_CMPA, OP_MOVEA:               return 1'b1;
            default:                                           return 1'b0;
        endcase
    endfunction

    // Extension-word target. Modes other than 5 and 6 decode as mode 7.
    function automatic fetch_state_t ea_target(input op_class_t cls, input logic [2:0] mode,
                                               input logic [2:0] rg, input logic is_long);
        if (mode == 3'd5) return FETCH_DISPL;
        if (mode == 3'd6) return FETCH_EXWORD_1;
        if (cls == CLS_SHIFT) return (rg == 3'd0) ? FETCH_ABS_LO : FETCH_ABS_HI;
        case (rg)
            3'd0:    return FETCH_ABS_LO;
            3'd1:    return FETCH_ABS_HI;
            3'd2:    return FETCH_DISPL;
            3'd4:    return is_long ? FETCH_IDATA_B2 : FETCH_IDATA_B1;
            default: return FETCH_EXWORD_1;
        endcase
    endfunction

    function automatic fetch_state_t model_next(input instr_t in, input hazard_t hz,
                                                input logic ack, input logic rdy);
        op_class_t    cls;
        logic         strict;
        logic [2:0]   mode;
        logic         is_long;
        fetch_state_t ea;
        fetch_state_t common;
        cls    = class_of(in.op);
        strict = strict_of(in.op);
        mode   = in.biw_0[5:3];
        if (cls == CLS_MOVE)
            is_long = (in.biw_0[13:12] == 2'b10);
        else
            is_long = (in.op_size == LONG);
        ea = ea_target(cls, mode, in.biw_0[2:0], is_long);
        case (mode)
            3'd0:       common = (hz.dr_in_use || (strict && cls == CLS_ALU_SRC && hz.ar_in_use))
                                 ? START_OP : INIT_EXEC_WB;
            3'd1:       common = (hz.ar_in_use || (strict && cls == CLS_ALU_DST && hz.dr_in_use))
                                 ? START_OP : INIT_EXEC_WB;
            3'd2, 3'd3: common = hz.ar_in_use ? START_OP : FETCH_OPERAND;
            3'd4:       common = hz.ar_in_use ? START_OP : CALC_AEFF;
            default:    common = ea;
        endcase
        if (!ack && !rdy) return START_OP; // Nothing available.
        case (cls)
            CLS_TRAP:    return START_OP;
            CLS_REG:     return hz.dr_in_use ? START_OP : INIT_EXEC_WB;
            CLS_XREG: begin
                if (!in.biw_0[3] && !hz.dr_in_use) return INIT_EXEC_WB;
                if (in.biw_0[3] && !hz.ar_in_use)  return CALC_AEFF;
                return START_OP;
            end
            CLS_SHIFT: begin
                if (in.biw_0[7:6] != 2'b11) return hz.dr_in_use ? START_OP : INIT_EXEC_WB;
                if (mode >= 3'd2 && mode <= 3'd4) return common;
                return ea;
            end
            CLS_SR_WAIT: return hz.alu_bsy ? START_OP : INIT_EXEC_WB;
            CLS_DEFAULT: return INIT_EXEC_WB;
            default:     return common; // ALU source, ALU destination and MOVE.
        endcase
    endfunction

    task automatic drive_random_vector();
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w2;
        w0 = lcg_next();
        w1 = lcg_next();
        w2 = lcg_next();
        instr.op      = op_t'(w0[6:0]); // Codes past the last group decode as default.
        instr.biw_0   = w1[13:0];
        instr.op_size = op_size_t'(w0[9:8] % 3);
        if (w0[15:13] == 3'd0) begin
            instr.op = OP_MOVE; // Single code, rare otherwise.
        end else if (w0[15:13] == 3'd1) begin
            instr.op         = w0[10] ? OP_ADDA : OP_ADD;
            instr.biw_0[5:4] = 2'b00; // Strict forms in register-direct modes.
        end
        if (w0[12:11] == 2'b00) begin
            instr.biw_0[5:0] = 6'b111_100; // Immediate operand.
        end
        hazard.dr_in_use = (w2[1:0] == 2'b00);
        hazard.ar_in_use = (w2[3:2] == 2'b00);
        hazard.alu_bsy   = (w2[5:4] == 2'b00);
        opd_ack = w2[6];
        ow_rdy  = w2[7];
    endtask

    initial begin : stimulus
        fetch_state_t expected;
        instr   = '0;
        hazard  = '0;
        opd_ack = 1'b0;
        ow_rdy  = 1'b0;
        @(negedge clk);
        while (!arst_n) begin
            check_value("fetch_state", fetch_state, START_OP); // Held in reset.
            @(negedge clk);
        end
        check_value("fetch_state", fetch_state, START_OP);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            drive_random_vector();
            expected = model_next(instr, hazard, opd_ack, ow_rdy);
            @(negedge clk); // Result registered at the rising edge in between.
            check_value("fetch_state", fetch_state, expected);
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/fetch_pkg.sv
design/op_class_decode.sv
design/hazard_gate.sv
design/ea_fetch_route.sv
design/start_op_dispatch.sv
testbench/tb_clock_gen.sv
testbench/tb_start_op_dispatch.sv
